// ==== hdl/slap_video_pkg.sv ====
`default_nettype none

package slap_video_pkg;

	// ==============================
	// raster geometry
	// ==============================
	localparam int H_TOTAL        = 384; // pixel clocks per line
	localparam int H_ACTIVE_START = 12;
	localparam int H_ACTIVE_END   = 268; // exclusive
	localparam int H_SYNC_START   = 300;
	localparam int H_SYNC_END     = 332;

	localparam int V_TOTAL        = 264; // lines per frame
	localparam int V_ACTIVE_START = 16;
	localparam int V_ACTIVE_END   = 240;
	localparam int V_SYNC_START   = 248;
	localparam int V_SYNC_END     = 252;

	localparam int H_W     = 9; // horizontal position width
	localparam int V_W     = 8; // vertical position width
	localparam int V_CNT_W = 9; // line counter is wider than V_W

	// ==============================
	// cpu register map
	// ==============================
	localparam logic [15:0] SCROLL_BASE       = 16'hE800; // hlo, hhi, v, mcu port
	localparam logic [15:0] SCROLL_BLOCK_MASK = 16'hFFFC;
	localparam logic [2:0]  FLIP_LATCH_SEL    = 3'd1;     // addressable latch output

	// ==============================
	// colour tables and download map
	// ==============================
	localparam int PAL_DEPTH = 256;
	localparam int PAL_W     = 4;

	localparam logic [1:0] DL_SEL_RED   = 2'd0; // dn_addr bits 9:8
	localparam logic [1:0] DL_SEL_GREEN = 2'd1;
	localparam logic [1:0] DL_SEL_BLUE  = 2'd2;

	// foreground layer has 64 palettes of 4 pens
	typedef struct packed {
		logic [5:0] pal;
		logic [1:0] pen;
	} fg_view_t;

	// sprite layer has 16 palettes of 16 pens
	typedef struct packed {
		logic [3:0] pal;
		logic [3:0] pen;
	} sp_view_t;

	// pen 0 is transparent in either view
	typedef union packed {
		fg_view_t fg;
		sp_view_t sp;
	} colour_index_t;

endpackage

`default_nettype wire

// ==== hdl/raster_if.sv ====
`default_nettype none

interface raster_if;
	import slap_video_pkg::*;

	logic [H_W-1:0]     hcnt;   // pixel within line
	logic [V_CNT_W-1:0] vcnt;   // line within frame
	logic               hblank;
	logic               vblank;
	logic               hsync;
	logic               vsync;

	// raster generator side
	modport timing_mp (
		output hcnt,
		output vcnt,
		output hblank,
		output vblank,
		output hsync,
		output vsync
	);

	// colour output side reads levels only
	modport video_mp (
		input hblank,
		input vblank,
		input hsync,
		input vsync
	);

endinterface

`default_nettype wire

// ==== hdl/scroll_regs.sv ====
`default_nettype none

module scroll_regs (
	input  wire logic                         pixel_clk,
	input  wire logic                         RESET_n,
	input  wire logic [15:0]                  cpu_addr_i,
	input  wire logic [7:0]                   cpu_data_i,
	input  wire logic                         cpu_mem_wr_i,
	input  wire logic                         cpu_io_wr_i,
	output logic      [slap_video_pkg::H_W-1:0] hscroll_o,
	output logic      [slap_video_pkg::V_W-1:0] vscroll_o,
	output logic                              flip_o
);
	import slap_video_pkg::*;

	logic scrl_wr;   // memory write inside the scroll block
	logic latch_wr;  // io write to the flip latch

	assign scrl_wr  = cpu_mem_wr_i && ((cpu_addr_i & SCROLL_BLOCK_MASK) == SCROLL_BASE);
	assign latch_wr = cpu_io_wr_i && (cpu_addr_i[3:1] == FLIP_LATCH_SEL);

	// ==============================
	// scroll block at E800..E803
	// ==============================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hscroll_o <= '0;
			vscroll_o <= '0;
		end else if (scrl_wr) begin
			case (cpu_addr_i[1:0])
				2'd0: hscroll_o[7:0] <= cpu_data_i;    // low byte
				2'd1: hscroll_o[8]   <= cpu_data_i[0]; // ninth bit only
				2'd2: vscroll_o      <= cpu_data_i;
				default: ;                             // mcu port is not kept
			endcase
		end
	end

	// addressable latch takes its data from address bit 0
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			flip_o <= 1'b0;
		end else if (latch_wr) begin
			flip_o <= cpu_addr_i[0];
		end
	end

	// a bus cycle is memory or io but never both
	a_wr_exclusive: assert property (
		@(posedge pixel_clk) disable iff (!RESET_n)
		!(cpu_mem_wr_i && cpu_io_wr_i)
	) else $error("memory and io write strobes high together");

endmodule

`default_nettype wire

// ==== hdl/raster_timing.sv ====
`default_nettype none

module raster_timing (
	input  wire logic                         pixel_clk,
	input  wire logic                         RESET_n,
	input  wire logic [slap_video_pkg::H_W-1:0] hscroll_i,
	input  wire logic [slap_video_pkg::V_W-1:0] vscroll_i,
	input  wire logic                         flip_i,
	raster_if.timing_mp                       ras,
	output logic      [slap_video_pkg::H_W-1:0] hpix_o,
	output logic      [slap_video_pkg::V_W-1:0] vpix_o,
	output logic      [slap_video_pkg::H_W-1:0] hpix_scrl_o,
	output logic      [slap_video_pkg::V_W-1:0] vpix_scrl_o
);
	import slap_video_pkg::*;

	logic line_end;  // last pixel of the line
	logic frame_end; // last line of the frame

	assign line_end  = (ras.hcnt == H_W'(H_TOTAL - 1));
	assign frame_end = (ras.vcnt == V_CNT_W'(V_TOTAL - 1));

	// ==============================
	// raster counters
	// ==============================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			ras.hcnt <= '0;
			ras.vcnt <= '0;
		end else begin
			ras.hcnt <= line_end ? '0 : ras.hcnt + 1'b1;
			if (line_end) begin
				ras.vcnt <= frame_end ? '0 : ras.vcnt + 1'b1;
			end
		end
	end

	// sync and blank windows from this clock's count
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			ras.hblank <= 1'b1; // count 0 lies in the border
			ras.vblank <= 1'b1;
			ras.hsync  <= 1'b0;
			ras.vsync  <= 1'b0;
		end else begin
			ras.hblank <= !((ras.hcnt >= H_ACTIVE_START) && (ras.hcnt < H_ACTIVE_END));
			ras.vblank <= !((ras.vcnt >= V_ACTIVE_START) && (ras.vcnt < V_ACTIVE_END));
			ras.hsync  <= (ras.hcnt >= H_SYNC_START) && (ras.hcnt < H_SYNC_END);
			ras.vsync  <= (ras.vcnt >= V_SYNC_START) && (ras.vcnt < V_SYNC_END);
		end
	end

	// ==============================
	// flipped and scrolled positions
	// ==============================
	// flip mirrors the line about its last pixel
	assign hpix_o = flip_i ? H_W'(H_TOTAL - 1) - ras.hcnt : ras.hcnt;
	assign vpix_o = flip_i ? ~ras.vcnt[V_W-1:0] : ras.vcnt[V_W-1:0];

	// adders wrap at their own width
	always_ff @(posedge pixel_clk) begin
		hpix_scrl_o <= hpix_o + hscroll_i; // mod 512
		vpix_scrl_o <= vpix_o + vscroll_i; // mod 256
	end

	a_cnt_range: assert property (
		@(posedge pixel_clk) disable iff (!RESET_n)
		(ras.hcnt < H_TOTAL) && (ras.vcnt < V_TOTAL)
	) else $error("raster counter beyond frame size");

endmodule

`default_nettype wire

// ==== hdl/layer_mixer.sv ====
`default_nettype none

module layer_mixer (
	input  wire logic                          pixel_clk,
	input  wire logic                          RESET_n,
	input  wire slap_video_pkg::colour_index_t fg_pix_i,
	input  wire slap_video_pkg::colour_index_t sp_pix_i,
	input  wire slap_video_pkg::colour_index_t bg_pix_i,
	output slap_video_pkg::colour_index_t      colour_idx_o
);
	import slap_video_pkg::*;

	logic          fg_opaque;
	logic          sp_opaque;
	colour_index_t mix_sel;

	// transparency is judged in each layer's own view
	assign fg_opaque = (fg_pix_i.fg.pen != '0);
	assign sp_opaque = (sp_pix_i.sp.pen != '0);

	// ==============================
	// priority fg > sprites > bg
	// ==============================
	always_comb begin
		if (fg_opaque) begin
			mix_sel = fg_pix_i;
		end else if (sp_opaque) begin
			mix_sel = sp_pix_i;
		end else begin
			mix_sel = bg_pix_i; // bg has no transparent pen
		end
	end

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			colour_idx_o <= '0;
		end else begin
			colour_idx_o <= mix_sel;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/colour_palette.sv ====
`default_nettype none

module colour_palette (
	input  wire logic                          pixel_clk,
	input  wire logic                          RESET_n,
	input  wire slap_video_pkg::colour_index_t colour_idx_i,
	input  wire logic [9:0]                    dn_addr_i,
	input  wire logic [7:0]                    dn_data_i,
	input  wire logic                          dn_wr_i,
	raster_if.video_mp                         ras,
	output logic      [slap_video_pkg::PAL_W-1:0] red_o,
	output logic      [slap_video_pkg::PAL_W-1:0] green_o,
	output logic      [slap_video_pkg::PAL_W-1:0] blue_o,
	output logic                               h_blank_o,
	output logic                               v_blank_o,
	output logic                               h_sync_o,
	output logic                               v_sync_o
);
	import slap_video_pkg::*;

	logic [PAL_W-1:0] red_mem   [PAL_DEPTH];
	logic [PAL_W-1:0] green_mem [PAL_DEPTH];
	logic [PAL_W-1:0] blue_mem  [PAL_DEPTH];

	logic [$clog2(PAL_DEPTH)-1:0] rd_addr;
	logic [$clog2(PAL_DEPTH)-1:0] wr_addr;
	logic [3:0]                   ras_d1; // {hblank, vblank, hsync, vsync}
	logic [3:0]                   ras_d2;

	assign rd_addr = colour_idx_i; // whole byte in either view
	assign wr_addr = dn_addr_i[7:0];

	// ==============================
	// download port
	// ==============================
	always_ff @(posedge pixel_clk) begin
		if (dn_wr_i) begin
			case (dn_addr_i[9:8])
				DL_SEL_RED:   red_mem[wr_addr]   <= dn_data_i[PAL_W-1:0];
				DL_SEL_GREEN: green_mem[wr_addr] <= dn_data_i[PAL_W-1:0];
				DL_SEL_BLUE:  blue_mem[wr_addr]  <= dn_data_i[PAL_W-1:0];
				default: ; // fourth slot unused
			endcase
		end
	end

	// one registered read of all three tables
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			red_o   <= '0;
			green_o <= '0;
			blue_o  <= '0;
		end else begin
			red_o   <= red_mem[rd_addr];
			green_o <= green_mem[rd_addr];
			blue_o  <= blue_mem[rd_addr];
		end
	end

	// ==============================
	// raster levels, two stages
	// ==============================
	// mixer stage plus table stage
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			ras_d1 <= 4'b1100; // blanked without sync
			ras_d2 <= 4'b1100;
		end else begin
			ras_d1 <= {ras.hblank, ras.vblank, ras.hsync, ras.vsync};
			ras_d2 <= ras_d1;
		end
	end

	assign h_blank_o = ras_d2[3];
	assign v_blank_o = ras_d2[2];
	assign h_sync_o  = ras_d2[1];
	assign v_sync_o  = ras_d2[0];

endmodule

`default_nettype wire

// ==== hdl/slap_video.sv ====
`default_nettype none

module slap_video (
	input  wire logic                          pixel_clk,
	input  wire logic                          RESET_n,
	// cpu side
	input  wire logic [15:0]                   cpu_addr_i,
	input  wire logic [7:0]                    cpu_data_i,
	input  wire logic                          cpu_mem_wr_i,
	input  wire logic                          cpu_io_wr_i,
	// layer pixels from the tile and sprite engines
	input  wire slap_video_pkg::colour_index_t fg_pix_i,
	input  wire slap_video_pkg::colour_index_t sp_pix_i,
	input  wire slap_video_pkg::colour_index_t bg_pix_i,
	// colour table download
	input  wire logic [9:0]                    dn_addr_i,
	input  wire logic [7:0]                    dn_data_i,
	input  wire logic                          dn_wr_i,
	// video out
	output logic      [slap_video_pkg::PAL_W-1:0] red_o,
	output logic      [slap_video_pkg::PAL_W-1:0] green_o,
	output logic      [slap_video_pkg::PAL_W-1:0] blue_o,
	output logic                               h_blank_o,
	output logic                               v_blank_o,
	output logic                               h_sync_o,
	output logic                               v_sync_o,
	// positions back to the layer engines
	output logic      [slap_video_pkg::H_W-1:0]   hpix_o,
	output logic      [slap_video_pkg::V_W-1:0]   vpix_o,
	output logic      [slap_video_pkg::H_W-1:0]   hpix_scrl_o,
	output logic      [slap_video_pkg::V_W-1:0]   vpix_scrl_o
);
	import slap_video_pkg::*;

	logic [H_W-1:0] hscroll;
	logic [V_W-1:0] vscroll;
	logic           flip;
	colour_index_t  colour_idx;

	raster_if ras ();

	scroll_regs u_scroll_regs (
		.pixel_clk    (pixel_clk),
		.RESET_n      (RESET_n),
		.cpu_addr_i   (cpu_addr_i),
		.cpu_data_i   (cpu_data_i),
		.cpu_mem_wr_i (cpu_mem_wr_i),
		.cpu_io_wr_i  (cpu_io_wr_i),
		.hscroll_o    (hscroll),
		.vscroll_o    (vscroll),
		.flip_o       (flip)
	);

	raster_timing u_raster_timing (
		.pixel_clk   (pixel_clk),
		.RESET_n     (RESET_n),
		.hscroll_i   (hscroll),
		.vscroll_i   (vscroll),
		.flip_i      (flip),
		.ras         (ras.timing_mp),
		.hpix_o      (hpix_o),
		.vpix_o      (vpix_o),
		.hpix_scrl_o (hpix_scrl_o),
		.vpix_scrl_o (vpix_scrl_o)
	);

	layer_mixer u_layer_mixer (
		.pixel_clk    (pixel_clk),
		.RESET_n      (RESET_n),
		.fg_pix_i     (fg_pix_i),
		.sp_pix_i     (sp_pix_i),
		.bg_pix_i     (bg_pix_i),
		.colour_idx_o (colour_idx)
	);

	colour_palette u_colour_palette (
		.pixel_clk    (pixel_clk),
		.RESET_n      (RESET_n),
		.colour_idx_i (colour_idx),
		.dn_addr_i    (dn_addr_i),
		.dn_data_i    (dn_data_i),
		.dn_wr_i      (dn_wr_i),
		.ras          (ras.video_mp),
		.red_o        (red_o),
		.green_o      (green_o),
		.blue_o       (blue_o),
		.h_blank_o    (h_blank_o),
		.v_blank_o    (v_blank_o),
		.h_sync_o     (h_sync_o),
		.v_sync_o     (v_sync_o)
	);

endmodule

`default_nettype wire

// ==== tb/tb_slap_video_model.svh ====
`ifndef TB_SLAP_VIDEO_MODEL_SVH
`define TB_SLAP_VIDEO_MODEL_SVH

// ==============================
// random source
// ==============================
logic [31:0] lcg_state = 32'h7177_2a61;

function automatic logic [31:0] next_rand();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// ==============================
// shadow state
// ==============================
logic [PAL_W-1:0] shadow_tab [3][PAL_DEPTH]; // red, green, blue
logic [2:0]       shadow_known [PAL_DEPTH] = '{default: '0};
logic [H_W-1:0]   sh_hscroll;
logic [V_W-1:0]   sh_vscroll;
logic             sh_flip;

// bus writes seen at this rising edge
task automatic shadow_writes();
	if (dn_wr_i && dn_addr_i[9:8] != 2'd3) begin
		shadow_tab[dn_addr_i[9:8]][dn_addr_i[7:0]] = dn_data_i[3:0];
		shadow_known[dn_addr_i[7:0]][dn_addr_i[9:8]] = 1'b1;
	end
	if (RESET_n && cpu_mem_wr_i && cpu_addr_i[15:2] == SCROLL_BASE[15:2]) begin
		case (cpu_addr_i[1:0])
			2'd0: sh_hscroll[7:0] = cpu_data_i;
			2'd1: sh_hscroll[8] = cpu_data_i[0];
			2'd2: sh_vscroll = cpu_data_i;
			default: ; // mcu port
		endcase
	end
	if (RESET_n && cpu_io_wr_i && cpu_addr_i[3:1] == FLIP_LATCH_SEL)
		sh_flip = cpu_addr_i[0];
endtask

// foreground wins, then sprites, background last
function automatic colour_index_t priority_pick(colour_index_t fg, colour_index_t sp,
		colour_index_t bg);
	if (fg.fg.pen != 2'd0)
		return fg;
	if (sp.sp.pen != 4'd0)
		return sp;
	return bg;
endfunction

function automatic logic [11:0] expected_rgb(logic [7:0] idx);
	return {shadow_tab[0][idx], shadow_tab[1][idx], shadow_tab[2][idx]};
endfunction

// {hblank, vblank, hsync, vsync} for c clocks after line 0 pixel 0
function automatic logic [3:0] expected_levels(longint c);
	int h;
	int v;
	if (c < 0)
		return 4'b1100; // reset levels still in the pipe
	h = int'(c % H_TOTAL);
	v = int'((c / H_TOTAL) % V_TOTAL);
	return {h < H_ACTIVE_START || h >= H_ACTIVE_END,
		v < V_ACTIVE_START || v >= V_ACTIVE_END,
		h >= H_SYNC_START && h < H_SYNC_END,
		v >= V_SYNC_START && v < V_SYNC_END};
endfunction

// {hpix, vpix} after k clocks
function automatic logic [16:0] expected_pos(longint k, logic flip);
	int h;
	int v;
	h = int'(k % H_TOTAL);
	v = int'((k / H_TOTAL) % V_TOTAL);
	if (flip)
		return {9'(H_TOTAL - 1 - h), ~8'(v)};
	return {9'(h), 8'(v)};
endfunction

`endif

// ==== tb/tb_slap_video.sv ====
`default_nettype none

module tb_slap_video;
	import slap_video_pkg::*;

	logic          pixel_clk = 1'b0;
	logic          RESET_n;
	logic [15:0]   cpu_addr_i;
	logic [7:0]    cpu_data_i;
	logic          cpu_mem_wr_i;
	logic          cpu_io_wr_i;
	logic          dn_wr_i;
	colour_index_t fg_pix_i;
	colour_index_t sp_pix_i;
	colour_index_t bg_pix_i;
	logic [9:0]    dn_addr_i;
	logic [7:0]    dn_data_i;
	logic [3:0]    red_o;
	logic [3:0]    green_o;
	logic [3:0]    blue_o;
	logic          h_blank_o;
	logic          v_blank_o;
	logic          h_sync_o;
	logic          v_sync_o;
	logic [8:0]    hpix_o;
	logic [8:0]    hpix_scrl_o;
	logic [7:0]    vpix_o;
	logic [7:0]    vpix_scrl_o;

	`include "tb_slap_video_model.svh"

	longint        edge_cnt = 0;   // rising edges since reset release
	colour_index_t exp_idx = '0;   // mixer stage of the model
	logic [11:0]   exp_rgb = '0;
	logic          exp_known = 1'b0;
	logic [8:0]    exp_hscrl = '0;
	logic [7:0]    exp_vscrl = '0;
	longint        last_hrise = -1;
	longint        last_vrise = -1;
	int            vrise_cnt = 0;
	int            check_cnt = 0;
	logic          prev_hsync = 1'b0;
	logic          prev_vsync = 1'b0;

	slap_video dut0 (.*);

	always #20 pixel_clk = ~pixel_clk;

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Testbench failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic value_fail(input string msg);
		stop_run($sformatf("Fail %0t: %s", $time, msg));
	endtask

	task automatic drive_pixels();
		logic [31:0] r;
		r = next_rand();
		fg_pix_i = r[7:0];
		sp_pix_i = r[15:8];
		bg_pix_i = r[23:16];
		if (r[24])
			fg_pix_i.fg.pen = '0; // often force transparent pens
		if (r[25])
			sp_pix_i.sp.pen = '0;
	endtask

	task automatic io_write(input logic [15:0] addr);
		@(negedge pixel_clk);
		cpu_addr_i  = addr;
		cpu_io_wr_i = 1'b1;
		@(negedge pixel_clk);
		cpu_io_wr_i = 1'b0;
	endtask

	task automatic check_direction(input logic down);
		logic [8:0] prev;
		logic [8:0] want;
		prev = 9'(expected_pos(edge_cnt, down) >> 8);
		repeat (H_TOTAL) begin
			@(negedge pixel_clk);
			if (down)
				want = (prev == 9'd0) ? 9'(H_TOTAL - 1) : prev - 9'd1;
			else
				want = (prev == 9'(H_TOTAL - 1)) ? 9'd0 : prev + 9'd1;
			assert (hpix_o == want)
				else value_fail($sformatf("hpix_o %0d, expected %0d", hpix_o, want));
			prev = want;
		end
	endtask

	// ==============================
	// model steps once per rising edge
	// ==============================
	always @(posedge pixel_clk) begin
		exp_rgb   = expected_rgb(exp_idx); // read sees the table before this edge's write
		exp_known = (shadow_known[exp_idx] == 3'b111);
		exp_idx   = RESET_n ? priority_pick(fg_pix_i, sp_pix_i, bg_pix_i) : '0;
		exp_hscrl = expected_pos(edge_cnt, sh_flip) >> 8;
		exp_hscrl = exp_hscrl + sh_hscroll; // wraps at 512
		exp_vscrl = 8'(expected_pos(edge_cnt, sh_flip)) + sh_vscroll;
		shadow_writes();
		if (RESET_n)
			edge_cnt++;
	end

	// ==============================
	// output comparison
	// ==============================
	always @(negedge pixel_clk) begin
		logic [16:0] pos;
		if (edge_cnt > 0) begin
			pos = expected_pos(edge_cnt, sh_flip);
			// levels leave 3 clocks after the count they belong to
			assert ({h_blank_o, v_blank_o, h_sync_o, v_sync_o} == expected_levels(edge_cnt - 3))
				else value_fail($sformatf("blank/sync levels %b at clock %0d",
					{h_blank_o, v_blank_o, h_sync_o, v_sync_o}, edge_cnt));
			assert ({hpix_o, vpix_o} == pos)
				else value_fail($sformatf("position %0d,%0d", hpix_o, vpix_o));
			assert (hpix_scrl_o == exp_hscrl && vpix_scrl_o == exp_vscrl)
				else value_fail($sformatf("scrolled position %0d,%0d expected %0d,%0d",
					hpix_scrl_o, vpix_scrl_o, exp_hscrl, exp_vscrl));
			if (exp_known) begin
				assert ({red_o, green_o, blue_o} == exp_rgb)
					else value_fail($sformatf("rgb %h, expected %h",
						{red_o, green_o, blue_o}, exp_rgb));
			end
			if (h_sync_o && !prev_hsync) begin
				assert (last_hrise < 0 || edge_cnt - last_hrise == H_TOTAL)
					else value_fail("h_sync_o period");
				last_hrise = edge_cnt;
			end
			if (v_sync_o && !prev_vsync) begin
				assert (last_vrise < 0 || edge_cnt - last_vrise == H_TOTAL * V_TOTAL)
					else value_fail("v_sync_o period");
				last_vrise = edge_cnt;
				vrise_cnt++;
			end
			prev_hsync = h_sync_o;
			prev_vsync = v_sync_o;
			check_cnt++;
		end
	end

	initial begin
		int          i;
		logic [31:0] r;
		RESET_n      = 1'b0;
		cpu_addr_i   = '0;
		cpu_data_i   = '0;
		cpu_mem_wr_i = 1'b0;
		cpu_io_wr_i  = 1'b0;
		fg_pix_i     = '0;
		sp_pix_i     = '0;
		bg_pix_i     = '0;
		dn_addr_i    = '0;
		dn_data_i    = '0;
		dn_wr_i      = 1'b0;
		sh_hscroll   = '0;
		sh_vscroll   = '0;
		sh_flip      = 1'b0;
		// entry 0 of each table black while in reset
		for (i = 0; i < 8; i++) begin
			@(negedge pixel_clk);
			dn_wr_i   = (i < 3);
			dn_addr_i = {i[1:0], 8'h00};
			dn_data_i = 8'hF0; // upper nibble not stored
		end
		@(negedge pixel_clk);
		dn_wr_i = 1'b0;
		RESET_n = 1'b1;

		i = 0;
		while (!h_sync_o) begin
			assert ({red_o, green_o, blue_o, v_sync_o} == 13'd0)
				else value_fail("rgb or v_sync_o not zero before first sync");
			@(negedge pixel_clk);
			i++;
			if (i > 2 * H_TOTAL)
				stop_run("timeout waiting for the first horizontal sync");
		end

		// random scroll, mcu port and latch writes
		for (i = 0; i < 600; i++) begin
			@(negedge pixel_clk);
			r = next_rand();
			cpu_mem_wr_i = r[0];
			cpu_io_wr_i  = r[1] && !r[0];
			cpu_addr_i   = r[2] ? SCROLL_BASE + 16'(r[4:3]) : r[31:16];
			cpu_data_i   = r[15:8];
		end
		@(negedge pixel_clk);
		cpu_mem_wr_i = 1'b0;
		cpu_io_wr_i  = 1'b0;

		io_write({12'h000, FLIP_LATCH_SEL, 1'b1});
		check_direction(1'b1);
		io_write({12'h000, FLIP_LATCH_SEL, 1'b0});
		check_direction(1'b0);

		// all three tables and then the unused slot
		for (i = 0; i < 3 * PAL_DEPTH + 64; i++) begin
			@(negedge pixel_clk);
			r = next_rand();
			dn_wr_i   = 1'b1;
			dn_addr_i = (i < 3 * PAL_DEPTH) ? 10'(i) : {2'd3, r[7:0]};
			dn_data_i = r[15:8];
			drive_pixels();
		end
		@(negedge pixel_clk);
		dn_wr_i = 1'b0;

		i = 0;
		while (vrise_cnt < 3) begin
			@(negedge pixel_clk);
			drive_pixels();
			i++;
			if (i > 3 * H_TOTAL * V_TOTAL)
				stop_run("timeout waiting for the third vertical sync");
		end

		if (check_cnt > 2 * H_TOTAL * V_TOTAL) begin
			$display("Testbench passed");
			$finish;
		end else begin
			stop_run("fewer output comparisons than two frames");
		end
	end

endmodule

`default_nettype wire

// ==== slap_video.f ====
+incdir+tb
hdl/slap_video_pkg.sv
hdl/raster_if.sv
hdl/scroll_regs.sv
hdl/raster_timing.sv
hdl/layer_mixer.sv
hdl/colour_palette.sv
hdl/slap_video.sv
tb/tb_slap_video.sv

// ==== Makefile ====
TOOL      := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_slap_video
FILE_LIST := slap_video.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_TEXT := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
